//--- board_ctrl.f
src/bc_pkg.sv
src/bus_decoder.sv
src/control_regs.sv
src/readback_mux.sv
src/local_reset.sv
src/board_ctrl.sv
test/tb_board_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --top-module tb_board_ctrl -f board_ctrl.f -o tb_board_ctrl \
	&& ./obj_dir/tb_board_ctrl | tee sim.log \
	|| { echo "Build or simulation did not complete"; exit 1; }

grep -q 'All tests passed!' sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }

//--- test/tb_board_ctrl.sv
`timescale 1ns/10ps

module tb_board_ctrl;
	import bc_pkg::*;

	localparam int DEBOUNCE_CYCLES  = 4;    // DUT defaults
	localparam int RST_PULSE_CYCLES = 16;
	localparam int WAIT_LIMIT       = 200;  // Cycles before a wait gives up
	localparam int ROUNDS           = 24;   // Random bus accesses per test

	logic                  bc_clk, arst_n;
	logic [BC_ADDR_W-1:0]  addr;
	logic                  cs_n, oe_n, we_n;
	logic [BC_DATA_W-1:0]  data_in, data_out;
	logic                  data_oe;
	logic [NUM_CE-1:0]     ce_n;
	logic [NUM_CTRL-1:0]   ctrl_n;
	logic [NUM_LED-1:0]    led;
	logic [NUM_STATUS-1:0] status;
	logic abort_n, hrst_btn_n, srst_btn_n, host_rst_n, hrst_sec_sel, srst_sec_dis;
	logic hrst_main_n, srst_main_n, hrst_sec_n, srst_sec_n, irq_n;

	logic [31:0] lfsr_state = 32'hc1e;
	logic [15:0] model_en;   // Enable n at bit n with bits 1:0 unused
	logic        model_irq;  // Abort pending
	int          errors, errors_at_start, tests_run, tests_failed;

	board_ctrl dut0 (
		.bc_clk (bc_clk), .arst_n (arst_n),
		.addr (addr), .cs_n (cs_n), .oe_n (oe_n), .we_n (we_n),
		.data_in (data_in), .data_out (data_out), .data_oe (data_oe), .ce_n (ce_n),
		.ctrl_n (ctrl_n), .led (led), .status (status),
		.abort_n (abort_n), .hrst_btn_n (hrst_btn_n), .srst_btn_n (srst_btn_n),
		.host_rst_n (host_rst_n), .hrst_sec_sel (hrst_sec_sel), .srst_sec_dis (srst_sec_dis),
		.hrst_main_n (hrst_main_n), .srst_main_n (srst_main_n),
		.hrst_sec_n (hrst_sec_n), .srst_sec_n (srst_sec_n), .irq_n (irq_n)
	);

	always #20 bc_clk = ~bc_clk;  // 40 ns period

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);  // One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	// Expected pins from the model
	function automatic logic [NUM_CTRL-1:0] exp_ctrl_n();
		return ~model_en[15:2];
	endfunction

	function automatic logic [NUM_LED-1:0] exp_led();
		return {model_en[13], model_en[14], model_en[15], model_en[6], model_en[5], model_en[4]};
	endfunction

	function automatic logic [7:0] exp_read(input int a);
		case (a)
			0: return {model_en[7:2], model_irq, 1'b0};  // Bit 0 always clear
			1: return model_en[15:8];
			2: return status[7:0];
			default: return status[15:8];
		endcase
	endfunction

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("FAIL %s expected %h got %h", name, exp, act);
		errors++;
	endtask

	task automatic report_text(input string what);
		$display("ERROR %s", what);
		errors++;
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (errors == errors_at_start) begin
			$display("test %0d %s: ok", tests_run, name);
		end else begin
			$display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
			tests_failed++;
		end
		errors_at_start = errors;
	endtask

	// Write with strobes held over edges A and A+1 and ending on the next falling edge
	task automatic bus_write(input logic [3:0] a, input logic [7:0] d);
		addr    = a;
		data_in = d;
		cs_n    = 1'b0;
		we_n    = 1'b0;
		repeat (2) @(negedge bc_clk);
		cs_n = 1'b1;
		we_n = 1'b1;
	endtask

	// One-cycle read with data sampled a half cycle after the edge
	task automatic check_read(input int a);
		logic [7:0] d;
		addr = 4'(a);
		cs_n = 1'b0;
		oe_n = 1'b0;
		@(negedge bc_clk);
		if (data_oe !== 1'b1) report_text("data_oe stayed low during a read");
		d    = data_out;
		cs_n = 1'b1;
		oe_n = 1'b1;
		if (d !== exp_read(a)) report_value("data_out", 32'(exp_read(a)), 32'(d));
	endtask

	task automatic check_outputs();
		if (ctrl_n !== exp_ctrl_n()) report_value("ctrl_n", 32'(exp_ctrl_n()), 32'(ctrl_n));
		if (led !== exp_led()) report_value("led", 32'(exp_led()), 32'(led));
		if (data_oe !== 1'b0) report_text("data_oe high while the bus is idle");
	endtask

	// Random enables with the command bits kept clear
	task automatic load_random_enables();
		logic [7:0] d;
		d = 8'(rand_bits(8)) | 8'h80;  // At least one enable on
		bus_write(ADDR_CTRL1, d);
		model_en[15:8] = d;
		@(negedge bc_clk);  // we_n seen high between the writes
		d = 8'(rand_bits(6)) << 2;
		bus_write(ADDR_CTRL0, d);
		model_en[7:2] = d[7:2];
		@(negedge bc_clk);
		check_outputs();
	endtask

	function automatic logic pulse_level(input int which);
		return (which == 0) ? hrst_main_n : srst_main_n;  // 0 hard, 1 soft
	endfunction

	// Waits for a low pulse and counts its falling-edge samples
	task automatic measure_pulse(input int which, input int exp_delay, output int len);
		int  t;
		logic exp_h, exp_s;
		t   = 0;
		len = 0;
		while (pulse_level(which) && t < WAIT_LIMIT) begin
			@(negedge bc_clk);
			t++;
		end
		if (t == WAIT_LIMIT) report_text("timeout waiting for a reset pulse to start");
		else if (t != exp_delay) report_value("pulse delay", 32'(exp_delay), 32'(t));
		exp_h = hrst_sec_sel ? (which != 0) : host_rst_n;  // Routed or host
		exp_s = srst_sec_dis ? 1'b1 : (which != 1);
		while (!pulse_level(which) && len < WAIT_LIMIT) begin
			if (hrst_sec_n !== exp_h) report_value("hrst_sec_n", 32'(exp_h), 32'(hrst_sec_n));
			if (srst_sec_n !== exp_s) report_value("srst_sec_n", 32'(exp_s), 32'(srst_sec_n));
			len++;
			@(negedge bc_clk);
		end
		if (len == WAIT_LIMIT) report_text("timeout waiting for a reset pulse to end");
	endtask

	initial begin
		logic [31:0] r;
		logic [3:0]  exp_ce;
		int          len, t;
		bc_clk = 1'b0;
		arst_n = 1'b0;
		addr = '0;
		cs_n = 1'b1;
		oe_n = 1'b1;
		we_n = 1'b1;
		data_in = '0;
		status = '0;
		abort_n = 1'b1;
		hrst_btn_n = 1'b1;
		srst_btn_n = 1'b1;
		host_rst_n = 1'b1;
		hrst_sec_sel = 1'b1;
		srst_sec_dis = 1'b0;
		model_en = '0;
		model_irq = 1'b0;
		errors = 0;
		errors_at_start = 0;
		tests_run = 0;
		tests_failed = 0;
		repeat (2) @(negedge bc_clk);  // Reset for 2 cycles
		arst_n = 1'b1;
		@(negedge bc_clk);

		// Idle state after reset
		check_outputs();
		if (ce_n !== 4'hf) report_value("ce_n", 32'hf, 32'(ce_n));
		if ({hrst_main_n, srst_main_n, hrst_sec_n, srst_sec_n, irq_n} !== 5'h1f)
			report_text("a reset or irq output is low after reset");
		finish_test("reset state");

		for (int i = 0; i < ROUNDS; i++) begin
			r = rand_bits(9);
			if (r[8]) begin
				bus_write(ADDR_CTRL1, r[7:0]);
				model_en[15:8] = r[7:0];
			end else begin
				bus_write(ADDR_CTRL0, {r[7:2], 2'b00});  // No reset commands
				model_en[7:2] = r[7:2];
			end
			check_outputs();
			check_read(int'(r[8]));
		end
		check_read(0);
		check_read(1);
		finish_test("control registers");

		for (int i = 0; i < ROUNDS; i++) begin
			status = 16'(rand_bits(16));
			check_read(2);
			check_read(3);
			addr   = 4'd4 + 4'(rand_bits(2));
			cs_n   = 1'b0;
			exp_ce = ~(4'b0001 << (addr - 4'd4));
			#10;  // Combinational decode settles
			if (ce_n !== exp_ce) report_value("ce_n", 32'(exp_ce), 32'(ce_n));
			@(negedge bc_clk);
			cs_n = 1'b1;
			#10;
			if (ce_n !== 4'hf) report_value("ce_n", 32'hf, 32'(ce_n));
			@(negedge bc_clk);
		end
		finish_test("status and chip enables");

		// Hard reset from the button routed to the secondary
		load_random_enables();
		hrst_sec_sel = 1'b1;
		hrst_btn_n   = 1'b0;
		measure_pulse(0, DEBOUNCE_CYCLES + 1, len);
		if (len != RST_PULSE_CYCLES) report_value("hrst_main_n width", RST_PULSE_CYCLES, len);
		model_en = '0;
		repeat (4) begin
			@(negedge bc_clk);
			if (hrst_main_n !== 1'b1) report_text("held button gave a second hard reset");
		end
		hrst_btn_n = 1'b1;
		check_outputs();
		// Hard reset command with the secondary left to the host
		load_random_enables();
		hrst_sec_sel = 1'b0;
		host_rst_n   = 1'b1;  // Host keeps the secondary running through the pulse
		bus_write(ADDR_CTRL0, {model_en[7:2], 2'b10});
		measure_pulse(0, 0, len);
		if (len != RST_PULSE_CYCLES) report_value("hrst_main_n width", RST_PULSE_CYCLES, len);
		model_en = '0;
		check_outputs();
		host_rst_n = 1'b0;
		@(negedge bc_clk);
		if (hrst_sec_n !== 1'b0) report_value("hrst_sec_n", 32'h0, 32'(hrst_sec_n));
		host_rst_n = 1'b1;
		finish_test("hard reset");

		load_random_enables();
		srst_sec_dis = 1'b1;
		bus_write(ADDR_CTRL0, {model_en[7:2], 2'b01});
		measure_pulse(1, 0, len);
		if (len != RST_PULSE_CYCLES) report_value("srst_main_n width", RST_PULSE_CYCLES, len);
		check_outputs();  // Enables survive a soft reset
		srst_sec_dis = 1'b0;
		srst_btn_n   = 1'b0;
		measure_pulse(1, DEBOUNCE_CYCLES + 1, len);
		srst_btn_n = 1'b1;
		if (len != RST_PULSE_CYCLES) report_value("srst_main_n width", RST_PULSE_CYCLES, len);
		check_outputs();
		finish_test("soft reset");

		abort_n = 1'b0;
		t = 0;
		while (irq_n && t < WAIT_LIMIT) begin
			@(negedge bc_clk);
			t++;
		end
		abort_n = 1'b1;
		if (t == WAIT_LIMIT) report_text("timeout waiting for irq_n after an abort");
		else if (t != DEBOUNCE_CYCLES + 1) report_value("irq_n delay", DEBOUNCE_CYCLES + 1, t);
		model_irq = 1'b1;
		check_read(0);
		bus_write(ADDR_STAT_LO, 8'(rand_bits(8)));  // Acknowledge
		model_irq = 1'b0;
		if (irq_n !== 1'b1) report_value("irq_n", 32'h1, 32'(irq_n));
		check_read(0);
		finish_test("abort interrupt");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- src/board_ctrl.sv
`timescale 1ns/10ps

module board_ctrl #(
	parameter int DEBOUNCE_CYCLES  = 4,
	parameter int RST_PULSE_CYCLES = 16
) (
	input  logic                          bc_clk,
	input  logic                          arst_n,
	// Local bus
	input  logic [bc_pkg::BC_ADDR_W-1:0]  addr,
	input  logic                          cs_n,
	input  logic                          oe_n,
	input  logic                          we_n,
	input  logic [bc_pkg::BC_DATA_W-1:0]  data_in,
	output logic [bc_pkg::BC_DATA_W-1:0]  data_out,
	output logic                          data_oe,   // Split bus, no tristate
	output logic [bc_pkg::NUM_CE-1:0]     ce_n,
	// Board control and status
	output logic [bc_pkg::NUM_CTRL-1:0]   ctrl_n,
	output logic [bc_pkg::NUM_LED-1:0]    led,
	input  logic [bc_pkg::NUM_STATUS-1:0] status,
	// Buttons and reset routing
	input  logic                          abort_n,
	input  logic                          hrst_btn_n,
	input  logic                          srst_btn_n,
	input  logic                          host_rst_n,
	input  logic                          hrst_sec_sel,
	input  logic                          srst_sec_dis,
	output logic                          hrst_main_n,
	output logic                          srst_main_n,
	output logic                          hrst_sec_n,
	output logic                          srst_sec_n,
	output logic                          irq_n
);
	import bc_pkg::*;

	logic [2:0]          wr_stb;    // Ctrl0, ctrl1, abort ack
	logic [3:0]          rd_sel;    // Readable addresses 0 to 3
	logic [NUM_CTRL-1:0] ctrl_en;   // Internal enables, active high
	logic                irq_pend;  // Abort latched

	bus_decoder bus_decoder_0 (
		.bc_clk (bc_clk),
		.arst_n (arst_n),
		.addr   (addr),
		.cs_n   (cs_n),
		.oe_n   (oe_n),
		.we_n   (we_n),
		.wr_stb (wr_stb),
		.rd_sel (rd_sel),
		.ce_n   (ce_n)
	);

	// Enables clear during the main hard reset pulse
	control_regs control_regs_0 (
		.bc_clk      (bc_clk),
		.arst_n      (arst_n),
		.hrst_main_n (hrst_main_n),
		.wr_stb      (wr_stb[1:0]),
		.data_in     (data_in),
		.ctrl_en     (ctrl_en),
		.ctrl_n      (ctrl_n),
		.led         (led)
	);

	readback_mux readback_mux_0 (
		.bc_clk   (bc_clk),
		.arst_n   (arst_n),
		.rd_sel   (rd_sel),
		.ctrl_en  (ctrl_en),
		.irq_pend (irq_pend),
		.status   (status),
		.data_out (data_out),
		.data_oe  (data_oe)
	);

	// Reset commands ride on ctrl0 data bits 1:0
	local_reset #(
		.DEBOUNCE_CYCLES  (DEBOUNCE_CYCLES),
		.RST_PULSE_CYCLES (RST_PULSE_CYCLES)
	) local_reset_0 (
		.bc_clk       (bc_clk),
		.arst_n       (arst_n),
		.abort_n      (abort_n),
		.hrst_btn_n   (hrst_btn_n),
		.srst_btn_n   (srst_btn_n),
		.host_rst_n   (host_rst_n),
		.hrst_sec_sel (hrst_sec_sel),
		.srst_sec_dis (srst_sec_dis),
		.cmd_stb      (wr_stb[0]),
		.ack_stb      (wr_stb[2]),
		.cmd          (data_in[1:0]),
		.hrst_main_n  (hrst_main_n),
		.srst_main_n  (srst_main_n),
		.hrst_sec_n   (hrst_sec_n),
		.srst_sec_n   (srst_sec_n),
		.irq_n        (irq_n),
		.irq_pend     (irq_pend)
	);

endmodule

//--- src/local_reset.sv
`timescale 1ns/10ps

module local_reset #(
	parameter int DEBOUNCE_CYCLES  = 4,   // Low samples needed on a button
	parameter int RST_PULSE_CYCLES = 16   // Reset pulse length
) (
	input  logic       bc_clk,
	input  logic       arst_n,
	input  logic       abort_n,       // Abort button
	input  logic       hrst_btn_n,    // Hard reset button
	input  logic       srst_btn_n,    // Soft reset button
	input  logic       host_rst_n,    // Host reset for the secondary CPU
	input  logic       hrst_sec_sel,  // 1 routes the main hard reset to the secondary
	input  logic       srst_sec_dis,  // 1 keeps the secondary out of soft reset
	input  logic       cmd_stb,       // Write to ctrl0
	input  logic       ack_stb,       // Write to the abort ack address
	input  logic [1:0] cmd,           // Bit 1 hard, bit 0 soft
	output logic       hrst_main_n,
	output logic       srst_main_n,
	output logic       hrst_sec_n,
	output logic       srst_sec_n,
	output logic       irq_n,
	output logic       irq_pend
);

	localparam int DB_W = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int PL_W = $clog2(RST_PULSE_CYCLES + 1);

	// Button slots
	localparam int BTN_ABORT = 0;
	localparam int BTN_HRST  = 1;
	localparam int BTN_SRST  = 2;
	localparam int NUM_BTN   = 3;

	// Pulse slots
	localparam int P_HARD = 0;
	localparam int P_SOFT = 1;
	localparam int NUM_P  = 2;

	logic [NUM_BTN-1:0] btn_n;      // Raw buttons
	logic [NUM_BTN-1:0] btn_req;    // Debounced press, one cycle
	logic [NUM_P-1:0]   pulse_req;  // Button or command
	logic [NUM_P-1:0]   pulse_on;   // Pulse running

	assign btn_n = {srst_btn_n, hrst_btn_n, abort_n};

	// Debounce with release tracking
	// A press counts once and the button must go high to re-arm
	for (genvar b = 0; b < NUM_BTN; b++) begin : g_debounce
		logic [DB_W-1:0] cnt;    // Consecutive low samples, saturating
		logic            armed;  // Released since the last request

		assign btn_req[b] = armed && (cnt == DB_W'(DEBOUNCE_CYCLES));

		always_ff @(posedge bc_clk or negedge arst_n) begin
			if (!arst_n) begin
				cnt   <= '0;
				armed <= 1'b1;
			end else if (btn_n[b]) begin
				cnt   <= '0;  // Released
				armed <= 1'b1;
			end else begin
				if (cnt != DB_W'(DEBOUNCE_CYCLES)) begin
					cnt <= cnt + 1'b1;
				end
				if (btn_req[b]) begin
					armed <= 1'b0;  // Consumed, even if a pulse ignores it
				end
			end
		end
	end

	// Software commands come with the ctrl0 write strobe
	assign pulse_req[P_HARD] = btn_req[BTN_HRST] || (cmd_stb && cmd[1]);
	assign pulse_req[P_SOFT] = btn_req[BTN_SRST] || (cmd_stb && cmd[0]);

	// Pulse counters
	// Requests that arrive while a pulse runs are dropped
	for (genvar p = 0; p < NUM_P; p++) begin : g_pulse
		logic [PL_W-1:0] cnt;  // Cycles left

		assign pulse_on[p] = (cnt != '0);

		always_ff @(posedge bc_clk or negedge arst_n) begin
			if (!arst_n) begin
				cnt <= '0;
			end else if (pulse_on[p]) begin
				cnt <= cnt - 1'b1;
			end else if (pulse_req[p]) begin
				cnt <= PL_W'(RST_PULSE_CYCLES);
			end
		end
	end

	assign hrst_main_n = !pulse_on[P_HARD];
	assign srst_main_n = !pulse_on[P_SOFT];

	// Secondary CPU reset routing
	assign hrst_sec_n = hrst_sec_sel ? hrst_main_n : host_rst_n;  // Else host owns it
	assign srst_sec_n = srst_sec_dis || srst_main_n;              // Held high when disabled

	// Abort latch
	// A new abort wins over an ack in the same cycle
	always_ff @(posedge bc_clk or negedge arst_n) begin
		if (!arst_n) begin
			irq_pend <= 1'b0;
		end else if (btn_req[BTN_ABORT]) begin
			irq_pend <= 1'b1;
		end else if (ack_stb) begin
			irq_pend <= 1'b0;
		end
	end

	assign irq_n = !irq_pend;  // Interrupt pin, active low

endmodule

//--- src/readback_mux.sv
`timescale 1ns/10ps

module readback_mux (
	input  logic                          bc_clk,
	input  logic                          arst_n,
	input  logic [3:0]                    rd_sel,    // One-hot, from the decoder
	input  logic [bc_pkg::NUM_CTRL-1:0]   ctrl_en,   // Enables 15:2
	input  logic                          irq_pend,  // Abort latched
	input  logic [bc_pkg::NUM_STATUS-1:0] status,
	output logic [bc_pkg::BC_DATA_W-1:0]  data_out,
	output logic                          data_oe
);
	import bc_pkg::*;

	localparam int REG0_BITS = BC_DATA_W - 2;  // Enables 7:2 in ctrl0

	logic [BC_DATA_W-1:0] rd_word;  // Word picked by the current address

	// Drive the bus for any readable address
	assign data_oe = |rd_sel;

	always_comb begin
		case (rd_sel)
			4'b0001: begin
				// Bit 1 shows the abort latch, bit 0 is always clear
				rd_word = {ctrl_en[REG0_BITS-1:0], irq_pend, 1'b0};
			end
			4'b0010: rd_word = ctrl_en[NUM_CTRL-1 -: BC_DATA_W];  // Enables 15:8
			4'b0100: rd_word = status[BC_DATA_W-1:0];              // Status low
			4'b1000: rd_word = status[NUM_STATUS-1 -: BC_DATA_W];  // Status high
			default: rd_word = '0;
		endcase
	end

	// Resample on every edge of the read
	always_ff @(posedge bc_clk or negedge arst_n) begin
		if (!arst_n) begin
			data_out <= '0;
		end else if (data_oe) begin
			data_out <= rd_word;
		end
	end

endmodule

//--- src/control_regs.sv
`timescale 1ns/10ps

module control_regs (
	input  logic                         bc_clk,
	input  logic                         arst_n,
	input  logic                         hrst_main_n,  // Main hard reset pulse
	input  logic [1:0]                   wr_stb,       // Ctrl0, ctrl1
	input  logic [bc_pkg::BC_DATA_W-1:0] data_in,
	output logic [bc_pkg::NUM_CTRL-1:0]  ctrl_en,      // 1 means enabled
	output logic [bc_pkg::NUM_CTRL-1:0]  ctrl_n,       // Pins, low means enabled
	output logic [bc_pkg::NUM_LED-1:0]   led
);
	import bc_pkg::*;

	// Vector bit 0 is enable 2, the lowest pin number
	localparam int CTRL_FIRST = 2;
	localparam int REG0_BITS  = BC_DATA_W - CTRL_FIRST;  // Enables 7:2
	localparam int REG1_LSB   = BC_DATA_W - CTRL_FIRST;  // Enable 8 sits here

	// Enable numbers shown on the LEDs, LED 0 first
	localparam int LED_PIN [NUM_LED] = '{4, 5, 6, 15, 14, 13};

	always_ff @(posedge bc_clk or negedge arst_n) begin
		if (!arst_n) begin
			ctrl_en <= '0;
		end else if (!hrst_main_n) begin
			ctrl_en <= '0;  // Everything off during main hard reset
		end else begin
			if (wr_stb[0]) begin
				// Bits 1:0 are reset commands and go to the reset block
				ctrl_en[0 +: REG0_BITS] <= data_in[BC_DATA_W-1:CTRL_FIRST];
			end
			if (wr_stb[1]) begin
				ctrl_en[REG1_LSB +: BC_DATA_W] <= data_in;  // Enables 15:8
			end
		end
	end

	// Physical pins are active low
	assign ctrl_n = ~ctrl_en;

	// LEDs light with their enable
	always_comb begin
		for (int i = 0; i < NUM_LED; i++) begin
			led[i] = ctrl_en[LED_PIN[i] - CTRL_FIRST];
		end
	end

endmodule

//--- src/bus_decoder.sv
`timescale 1ns/10ps

module bus_decoder (
	input  logic                         bc_clk,
	input  logic                         arst_n,
	input  logic [bc_pkg::BC_ADDR_W-1:0] addr,
	input  logic                         cs_n,
	input  logic                         oe_n,
	input  logic                         we_n,
	output logic [2:0]                   wr_stb,  // Ctrl0, ctrl1, abort ack
	output logic [3:0]                   rd_sel,  // One per readable address
	output logic [bc_pkg::NUM_CE-1:0]    ce_n
);
	import bc_pkg::*;

	logic we_n_q;    // we_n as sampled at the last edge
	logic wr_start;  // First edge of a write access
	logic rd_cycle;  // Read strobes active

	// A write counts once, on the edge where we_n is first seen low
	assign wr_start = !cs_n && !we_n && we_n_q;
	assign rd_cycle = !cs_n && !oe_n && we_n;

	always_ff @(posedge bc_clk or negedge arst_n) begin
		if (!arst_n) begin
			we_n_q <= 1'b1;  // Bus idle
			wr_stb <= '0;
		end else begin
			we_n_q <= we_n;
			// One-cycle pulses at the address of edge A
			wr_stb[0] <= wr_start && (addr == ADDR_CTRL0);
			wr_stb[1] <= wr_start && (addr == ADDR_CTRL1);
			wr_stb[2] <= wr_start && (addr == ADDR_STAT_LO);  // Abort ack
		end
	end

	// Read selects are levels for the whole read
	always_comb begin
		rd_sel = '0;
		if (rd_cycle) begin
			rd_sel[0] = (addr == ADDR_CTRL0);
			rd_sel[1] = (addr == ADDR_CTRL1);
			rd_sel[2] = (addr == ADDR_STAT_LO);
			rd_sel[3] = (addr == ADDR_STAT_HI);
		end
	end

	// External chip enables
	// Follow address and chip select without waiting for a strobe
	always_comb begin
		for (int i = 0; i < NUM_CE; i++) begin
			ce_n[i] = !(!cs_n && (addr == ADDR_CE_BASE + BC_ADDR_W'(i)));
		end
	end

endmodule

//--- src/bc_pkg.sv
package bc_pkg;

	// Local bus
	localparam int BC_ADDR_W = 4;  // Address lines
	localparam int BC_DATA_W = 8;  // Data lines

	// Board outputs
	localparam int NUM_CTRL = 14;  // Control enables 15:2
	localparam int NUM_LED  = 6;   // LEDs mirroring six enables
	localparam int NUM_CE   = 4;   // External chip enables

	// Board inputs
	localparam int NUM_STATUS = 16;  // Status pins read back in two bytes

	// Register map
	// Control register 0
	// Bits 7:2 hold enables 7:2
	// Bit 0 requests a soft reset and bit 1 a hard reset, neither is stored
	localparam logic [BC_ADDR_W-1:0] ADDR_CTRL0 = 4'd0;

	// Control register 1 holds enables 15:8
	localparam logic [BC_ADDR_W-1:0] ADDR_CTRL1 = 4'd1;

	// Status low byte
	// A write here acknowledges the abort interrupt
	localparam logic [BC_ADDR_W-1:0] ADDR_STAT_LO = 4'd2;

	// Status high byte
	localparam logic [BC_ADDR_W-1:0] ADDR_STAT_HI = 4'd3;

	// Addresses 4 to 7 select chip enables 0 to 3
	localparam logic [BC_ADDR_W-1:0] ADDR_CE_BASE = 4'd4;

endpackage
